//--- cosPkg.sv
// Management shell package with bus types, register map and protocol constants
`default_nettype none

package cosPkg;

  // ************************************************************
  // Bus and stream types
  // ************************************************************

  // Master to slave AXI4-Lite signals
  typedef struct packed {
    logic        awValid;
    logic [7:0]  awAddr;
    logic        wValid;
    logic [31:0] wData;
    logic [3:0]  wStrb;
    logic        bReady;
    logic        arValid;
    logic [7:0]  arAddr;
    logic        rReady;
  } axilReq_t;

  // Slave to master AXI4-Lite signals
  typedef struct packed {
    logic        awReady;
    logic        wReady;
    logic        bValid;
    logic [1:0]  bResp;
    logic        arReady;
    logic        rValid;
    logic [31:0] rData;
    logic [1:0]  rResp;
  } axilRsp_t;

  // One UART byte in flight
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } byteStream_t;

  // Bit period timer, wide enough for the baud settings below
  typedef logic [7:0] bitTimer_t;

  // ************************************************************
  // Register map and protocol codes
  // ************************************************************

  localparam logic [7:0]  AddrId      = 8'h00;
  localparam logic [7:0]  AddrScratch = 8'h04;
  localparam logic [7:0]  AddrLed     = 8'h08;
  localparam logic [31:0] CosId       = 32'h0C05_0001;
  localparam int          LedCount    = 3;

  localparam logic [7:0] OpWrite     = 8'h57;
  localparam logic [7:0] OpRead      = 8'h52;
  localparam logic [7:0] StatusOk    = 8'h4B;
  localparam logic [7:0] StatusErr   = 8'h45;
  localparam logic [7:0] StatusBadOp = 8'h3F;

  localparam logic [1:0] RespOkay   = 2'd0;
  localparam logic [1:0] RespSlvErr = 2'd2;

  // Command ports and their bit periods in clock cycles
  localparam int UartCount         = 2;
  localparam int ClocksPerBitPort0 = 16;
  localparam int ClocksPerBitPort1 = 24;

endpackage

`default_nettype wire

//--- uartLink.sv
// Full-duplex 8N1 UART with a parameterized bit period
`timescale 1ns/1ps
`default_nettype none

module uartLink #(
  parameter int ClocksPerBit = cosPkg::ClocksPerBitPort0
) (
  input  wire logic                clockRef,
  input  wire logic                arstN,
  input  wire logic                rxLine,
  output logic                     txLine,
  output cosPkg::byteStream_t      rxByte,
  input  wire cosPkg::byteStream_t txByte,
  output logic                     txReady
);

  typedef enum logic [1:0] {RxIdle, RxStart, RxData, RxStop} rxState_t;

  rxState_t          rxState;
  logic [1:0]        rxSync;
  cosPkg::bitTimer_t rxTimer;
  logic [2:0]        rxBitIdx;
  logic [7:0]        rxShift;
  logic              rxValid;

  logic              txBusy;
  cosPkg::bitTimer_t txTimer;
  logic [3:0]        txBitIdx;
  logic [9:0]        txShift;

  // ************************************************************
  // Receiver
  // ************************************************************

  // Two-flop synchronizer, idle high
  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      rxSync <= 2'b11;
    end else begin
      rxSync <= {rxSync[0], rxLine};
    end
  end

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      rxState  <= RxIdle;
      rxTimer  <= '0;
      rxBitIdx <= '0;
      rxValid  <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      if (rxState != RxIdle && rxTimer != '0) begin
        rxTimer <= rxTimer - 1'b1;
      end else begin
        case (rxState)
          RxIdle: begin
            // Falling edge, wait half a bit to land mid start bit
            if (!rxSync[1]) begin
              rxTimer <= cosPkg::bitTimer_t'(ClocksPerBit / 2 - 1);
              rxState <= RxStart;
            end
          end
          RxStart: begin
            rxTimer  <= cosPkg::bitTimer_t'(ClocksPerBit - 1);
            rxBitIdx <= '0;
            rxState  <= rxSync[1] ? RxIdle : RxData;
          end
          RxData: begin
            rxTimer  <= cosPkg::bitTimer_t'(ClocksPerBit - 1);
            rxBitIdx <= rxBitIdx + 1'b1;
            if (rxBitIdx == 3'd7) begin
              rxState <= RxStop;
            end
          end
          default: begin
            // Low stop bit means a framing error, drop the byte
            rxValid <= rxSync[1];
            rxState <= RxIdle;
          end
        endcase
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clockRef) begin
    if (rxState == RxData && rxTimer == '0) begin
      rxShift <= {rxSync[1], rxShift[7:1]};
    end
  end

  assign rxByte = '{valid: rxValid, data: rxShift};

  // ************************************************************
  // Transmitter
  // ************************************************************

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      txBusy   <= 1'b0;
      txTimer  <= '0;
      txBitIdx <= '0;
      txShift  <= '1;
    end else if (!txBusy) begin
      if (txByte.valid) begin
        // Stop bit, data, start bit
        txShift  <= {1'b1, txByte.data, 1'b0};
        txTimer  <= cosPkg::bitTimer_t'(ClocksPerBit - 1);
        txBitIdx <= '0;
        txBusy   <= 1'b1;
      end
    end else if (txTimer != '0) begin
      txTimer <= txTimer - 1'b1;
    end else begin
      txShift  <= {1'b1, txShift[9:1]};
      txTimer  <= cosPkg::bitTimer_t'(ClocksPerBit - 1);
      txBitIdx <= txBitIdx + 1'b1;
      if (txBitIdx == 4'd9) begin
        txBusy <= 1'b0;
      end
    end
  end

  assign txLine  = txShift[0];
  assign txReady = !txBusy;

endmodule

`default_nettype wire

//--- cmdEngine.sv
// UART command frame parser and response builder acting as an AXI4-Lite master
`timescale 1ns/1ps
`default_nettype none

module cmdEngine (
  input  wire logic                clockRef,
  input  wire logic                arstN,
  input  wire cosPkg::byteStream_t rxByte,
  output cosPkg::byteStream_t      txByte,
  input  wire logic                txReady,
  output cosPkg::axilReq_t         busReq,
  input  wire cosPkg::axilRsp_t    busRsp
);

  typedef enum logic [2:0] {
    StRxOp,
    StRxAddr,
    StRxData,
    StBusWrite,
    StBusRead,
    StTx
  } engState_t;

  engState_t   state;
  logic        isWrite;
  logic [1:0]  byteCnt;
  logic        awPend;
  logic        wPend;
  logic        arPend;
  logic [2:0]  txCount;
  logic [7:0]  addr;
  logic [31:0] wData;
  logic [39:0] txShift;

  // ************************************************************
  // Frame FSM
  // ************************************************************

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      state   <= StRxOp;
      isWrite <= 1'b0;
      byteCnt <= '0;
      awPend  <= 1'b0;
      wPend   <= 1'b0;
      arPend  <= 1'b0;
      txCount <= '0;
    end else begin
      case (state)
        StRxOp: begin
          if (rxByte.valid) begin
            if (rxByte.data == cosPkg::OpWrite || rxByte.data == cosPkg::OpRead) begin
              isWrite <= (rxByte.data == cosPkg::OpWrite);
              state   <= StRxAddr;
            end else begin
              // Unknown opcode, answer at once
              txCount <= 3'd1;
              state   <= StTx;
            end
          end
        end
        StRxAddr: begin
          if (rxByte.valid) begin
            byteCnt <= '0;
            arPend  <= !isWrite;
            state   <= isWrite ? StRxData : StBusRead;
          end
        end
        StRxData: begin
          if (rxByte.valid) begin
            byteCnt <= byteCnt + 1'b1;
            if (byteCnt == 2'd3) begin
              awPend <= 1'b1;
              wPend  <= 1'b1;
              state  <= StBusWrite;
            end
          end
        end
        StBusWrite: begin
          if (busRsp.awReady) awPend <= 1'b0;
          if (busRsp.wReady) wPend <= 1'b0;
          if (busRsp.bValid) begin
            txCount <= 3'd1;
            state   <= StTx;
          end
        end
        StBusRead: begin
          if (busRsp.arReady) arPend <= 1'b0;
          if (busRsp.rValid) begin
            // Status plus four data bytes only on OKAY
            txCount <= (busRsp.rResp == cosPkg::RespOkay) ? 3'd5 : 3'd1;
            state   <= StTx;
          end
        end
        default: begin
          if (txReady) begin
            txCount <= txCount - 1'b1;
            if (txCount == 3'd1) state <= StRxOp;
          end
        end
      endcase
    end
  end

  // Frame payload and response queue
  always_ff @(posedge clockRef) begin
    if (state == StRxAddr && rxByte.valid) begin
      addr <= rxByte.data;
    end
    if (state == StRxData && rxByte.valid) begin
      wData <= {wData[23:0], rxByte.data};
    end
    if (state == StRxOp && rxByte.valid) begin
      txShift <= {cosPkg::StatusBadOp, 32'h0};
    end else if (state == StBusWrite && busRsp.bValid) begin
      txShift <= {(busRsp.bResp == cosPkg::RespOkay) ? cosPkg::StatusOk : cosPkg::StatusErr,
                  32'h0};
    end else if (state == StBusRead && busRsp.rValid) begin
      txShift <= {(busRsp.rResp == cosPkg::RespOkay) ? cosPkg::StatusOk : cosPkg::StatusErr,
                  busRsp.rData};
    end else if (state == StTx && txReady) begin
      txShift <= {txShift[31:0], 8'h00};
    end
  end

  // ************************************************************
  // Outputs
  // ************************************************************

  always_comb begin
    busReq         = '0;
    busReq.awValid = awPend;
    busReq.awAddr  = addr;
    busReq.wValid  = wPend;
    busReq.wData   = wData;
    busReq.wStrb   = 4'hF;
    busReq.bReady  = (state == StBusWrite);
    busReq.arValid = arPend;
    busReq.arAddr  = addr;
    busReq.rReady  = (state == StBusRead);
  end

  assign txByte = '{valid: (state == StTx), data: txShift[39:32]};

endmodule

`default_nettype wire

//--- axilArbiter.sv
// Two-master round-robin AXI4-Lite arbiter, one whole transaction per grant
`timescale 1ns/1ps
`default_nettype none

module axilArbiter (
  input  wire logic             clockRef,
  input  wire logic             arstN,
  input  wire cosPkg::axilReq_t mstReq [2],
  output cosPkg::axilRsp_t      mstRsp [2],
  output cosPkg::axilReq_t      slvReq,
  input  wire cosPkg::axilRsp_t slvRsp
);

  logic       owner;
  logic       busy;
  logic       lastServed;
  logic [1:0] reqVec;
  logic       winner;
  logic       txnDone;

  // ************************************************************
  // Grant control
  // ************************************************************

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      reqVec[i] = mstReq[i].awValid || mstReq[i].arValid;
    end
  end

  // Both requesting, the one not served last wins
  always_comb begin
    if (reqVec == 2'b11) begin
      winner = !lastServed;
    end else begin
      winner = reqVec[1];
    end
  end

  // End of transaction on the B or R handshake
  assign txnDone = busy && ((slvRsp.bValid && slvReq.bReady) ||
                            (slvRsp.rValid && slvReq.rReady));

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      owner      <= 1'b0;
      busy       <= 1'b0;
      lastServed <= 1'b1;
    end else if (!busy) begin
      if (reqVec != 2'b00) begin
        owner <= winner;
        busy  <= 1'b1;
      end
    end else if (txnDone) begin
      busy       <= 1'b0;
      lastServed <= owner;
    end
  end

  // ************************************************************
  // Request and response routing
  // ************************************************************

  always_comb begin
    slvReq = '0;
    if (busy) begin
      slvReq = mstReq[owner];
    end
  end

  // Master without the grant sees all zeros
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      mstRsp[i] = '0;
      if (busy && owner == i[0]) begin
        mstRsp[i] = slvRsp;
      end
    end
  end

endmodule

`default_nettype wire

//--- statusRegs.sv
// AXI4-Lite slave with identity, scratch and LED registers
`timescale 1ns/1ps
`default_nettype none

module statusRegs (
  input  wire logic                          clockRef,
  input  wire logic                          arstN,
  input  wire cosPkg::axilReq_t              busReq,
  output cosPkg::axilRsp_t                   busRsp,
  output logic [cosPkg::LedCount-1:0]        ledOut
);

  logic                        bPending;
  logic [1:0]                  bResp;
  logic                        rPending;
  logic [1:0]                  rResp;
  logic [31:0]                 rData;
  logic [31:0]                 scratch;
  logic [cosPkg::LedCount-1:0] led;
  logic                        wrFire;
  logic                        rdFire;
  logic                        wrHit;

  assign wrFire = busReq.awValid && busReq.wValid && !bPending;
  assign rdFire = busReq.arValid && !rPending;

  // Identity is read only, anything else unmapped or unaligned
  assign wrHit = (busReq.awAddr == cosPkg::AddrScratch) || (busReq.awAddr == cosPkg::AddrLed);

  // ************************************************************
  // Write path
  // ************************************************************

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      bPending <= 1'b0;
      scratch  <= '0;
      led      <= '0;
    end else begin
      if (wrFire) begin
        bPending <= 1'b1;
        if (busReq.awAddr == cosPkg::AddrScratch) scratch <= busReq.wData;
        if (busReq.awAddr == cosPkg::AddrLed) led <= busReq.wData[cosPkg::LedCount-1:0];
      end else if (bPending && busReq.bReady) begin
        bPending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clockRef) begin
    if (wrFire) begin
      bResp <= wrHit ? cosPkg::RespOkay : cosPkg::RespSlvErr;
    end
  end

  // ************************************************************
  // Read path
  // ************************************************************

  always_ff @(posedge clockRef or negedge arstN) begin
    if (!arstN) begin
      rPending <= 1'b0;
    end else if (rdFire) begin
      rPending <= 1'b1;
    end else if (rPending && busReq.rReady) begin
      rPending <= 1'b0;
    end
  end

  always_ff @(posedge clockRef) begin
    if (rdFire) begin
      rResp <= cosPkg::RespOkay;
      case (busReq.arAddr)
        cosPkg::AddrId:      rData <= cosPkg::CosId;
        cosPkg::AddrScratch: rData <= scratch;
        cosPkg::AddrLed:     rData <= {{(32 - cosPkg::LedCount){1'b0}}, led};
        default: begin
          rData <= '0;
          rResp <= cosPkg::RespSlvErr;
        end
      endcase
    end
  end

  always_comb begin
    busRsp         = '0;
    busRsp.awReady = !bPending;
    busRsp.wReady  = !bPending;
    busRsp.bValid  = bPending;
    busRsp.bResp   = bResp;
    busRsp.arReady = !rPending;
    busRsp.rValid  = rPending;
    busRsp.rData   = rData;
    busRsp.rResp   = rResp;
  end

  assign ledOut = led;

endmodule

`default_nettype wire

//--- chipCore.sv
// Management shell core with two UART command ports sharing one register block
`timescale 1ns/1ps
`default_nettype none

module chipCore (
  input  wire logic                           clockRef,
  input  wire logic                           arstN,
  input  wire logic [cosPkg::UartCount-1:0]   uartRx,
  output logic      [cosPkg::UartCount-1:0]   uartTx,
  output logic      [cosPkg::LedCount-1:0]    ledOut
);

  cosPkg::byteStream_t           rxStream [cosPkg::UartCount];
  cosPkg::byteStream_t           txStream [cosPkg::UartCount];
  logic [cosPkg::UartCount-1:0]  txReady;
  cosPkg::axilReq_t              engReq [2];
  cosPkg::axilRsp_t              engRsp [2];
  cosPkg::axilReq_t              regReq;
  cosPkg::axilRsp_t              regRsp;

  // ************************************************************
  // Command ports, each with its own baud rate
  // ************************************************************

  for (genvar i = 0; i < cosPkg::UartCount; i++) begin : gPort
    uartLink #(
      .ClocksPerBit(i == 0 ? cosPkg::ClocksPerBitPort0 : cosPkg::ClocksPerBitPort1)
    ) uUartLink (
      .clockRef (clockRef),
      .arstN    (arstN),
      .rxLine   (uartRx[i]),
      .txLine   (uartTx[i]),
      .rxByte   (rxStream[i]),
      .txByte   (txStream[i]),
      .txReady  (txReady[i])
    );

    cmdEngine uCmdEngine (
      .clockRef (clockRef),
      .arstN    (arstN),
      .rxByte   (rxStream[i]),
      .txByte   (txStream[i]),
      .txReady  (txReady[i]),
      .busReq   (engReq[i]),
      .busRsp   (engRsp[i])
    );
  end

  // Shared register block behind the arbiter
  axilArbiter uAxilArbiter (
    .clockRef (clockRef),
    .arstN    (arstN),
    .mstReq   (engReq),
    .mstRsp   (engRsp),
    .slvReq   (regReq),
    .slvRsp   (regRsp)
  );

  statusRegs uStatusRegs (
    .clockRef (clockRef),
    .arstN    (arstN),
    .busReq   (regReq),
    .busRsp   (regRsp),
    .ledOut   (ledOut)
  );

endmodule

`default_nettype wire

//--- cosTb_chk.sv
// Assertions on the AXI4-Lite arbiter grant and response handshakes
`timescale 1ns/1ps
`default_nettype none

module cosTb_chk (
  input wire logic             clockRef,
  input wire logic             arstN,
  input wire cosPkg::axilReq_t mstReq [2],
  input wire cosPkg::axilRsp_t mstRsp [2],
  input wire cosPkg::axilReq_t slvReq,
  input wire cosPkg::axilRsp_t slvRsp,
  input wire logic             owner,
  input wire logic             busy
);

  logic [1:0] readySeen;
  logic [1:0] reqSeen;
  logic       ownerReq;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      readySeen[i] = mstRsp[i].awReady || mstRsp[i].wReady || mstRsp[i].arReady;
      reqSeen[i]   = mstReq[i].awValid || mstReq[i].arValid;
    end
  end

  assign ownerReq = reqSeen[owner];

  // Only the grant owner may see slave ready
  aOneReady: assert property (@(posedge clockRef) disable iff (!arstN)
    readySeen != 2'b11)
    else $error("both masters see slave ready in the same cycle");

  aBValidHold: assert property (@(posedge clockRef) disable iff (!arstN)
    slvRsp.bValid && !slvReq.bReady |=> slvRsp.bValid)
    else $error("bValid dropped before bReady");

  aRValidHold: assert property (@(posedge clockRef) disable iff (!arstN)
    slvRsp.rValid && !slvReq.rReady |=> slvRsp.rValid)
    else $error("rValid dropped before rReady");

  // Owner moves only to a master with a request pending
  aOwnerStable: assert property (@(posedge clockRef) disable iff (!arstN)
    owner != $past(owner) |-> ownerReq)
    else $error("grant owner changed without a request from the new owner");

endmodule

`default_nettype wire

//--- cosTb.sv
// Directed testbench driving the management shell core through both UART command ports
`timescale 1ns/1ps
`default_nettype none

module cosTb;

  // Worst-case run is about 20000 cycles of frames, so this leaves margin
  localparam int TimeoutCycles = 30000;

  logic                          clockRef;
  logic                          arstN;
  logic [cosPkg::UartCount-1:0]  uartRx;
  logic [cosPkg::UartCount-1:0]  uartTx;
  logic [cosPkg::LedCount-1:0]   ledOut;
  int                            cycleCount = 0;
  logic [31:0]                   lcgState;
  logic [31:0]                   expScratch;
  logic [cosPkg::LedCount-1:0]   expLed;

  chipCore i_chipCore (
    .clockRef (clockRef),
    .arstN    (arstN),
    .uartRx   (uartRx),
    .uartTx   (uartTx),
    .ledOut   (ledOut)
  );

  bind axilArbiter cosTb_chk uCosTbChk (
    .clockRef (clockRef),
    .arstN    (arstN),
    .mstReq   (mstReq),
    .mstRsp   (mstRsp),
    .slvReq   (slvReq),
    .slvRsp   (slvRsp),
    .owner    (owner),
    .busy     (busy)
  );

  initial clockRef = 1'b0;
  always #4 clockRef = ~clockRef;

  always @(posedge clockRef) begin
    cycleCount++;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", TimeoutCycles);
      $display("Errors found");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // ************************************************************
  // Helpers
  // ************************************************************

  function automatic int bitPeriod(input int port);
    return (port == 0) ? cosPkg::ClocksPerBitPort0 : cosPkg::ClocksPerBitPort1;
  endfunction

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "value check failed");
    end
  endtask

  // Start bit, 8 data bits LSB first, stop bit
  task automatic uartSend(input int port, input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clockRef);
      uartRx[port] <= frame[i];
      repeat (bitPeriod(port) - 1) @(posedge clockRef);
    end
  endtask

  // Sample on falling clock edges, mid bit
  task automatic uartRecv(input int port, output logic [7:0] data);
    @(negedge clockRef);
    while (uartTx[port] !== 1'b0) begin
      @(negedge clockRef);
    end
    repeat (bitPeriod(port) / 2) @(negedge clockRef);
    checkEq(uartTx[port], 1'b0, $sformatf("start bit on port %0d", port));
    for (int i = 0; i < 8; i++) begin
      repeat (bitPeriod(port)) @(negedge clockRef);
      data[i] = uartTx[port];
    end
    repeat (bitPeriod(port)) @(negedge clockRef);
    checkEq(uartTx[port], 1'b1, $sformatf("stop bit on port %0d", port));
  endtask

  // Frame out and response in run side by side
  task automatic runCmd(input int port, input logic [7:0] frame[$], output logic [7:0] status,
                        output logic [31:0] data);
    logic [7:0] rspByte;
    data = '0;
    fork
      foreach (frame[i]) uartSend(port, frame[i]);
      begin
        uartRecv(port, status);
        if (frame[0] == cosPkg::OpRead && status == cosPkg::StatusOk) begin
          for (int i = 0; i < 4; i++) begin
            uartRecv(port, rspByte);
            data = {data[23:0], rspByte};
          end
        end
      end
    join
  endtask

  task automatic writeReg(input int port, input logic [7:0] addr, input logic [31:0] wData,
                          input logic [7:0] expStatus);
    logic [7:0]  frame[$];
    logic [7:0]  status;
    logic [31:0] rData;
    frame.push_back(cosPkg::OpWrite);
    frame.push_back(addr);
    for (int i = 3; i >= 0; i--) begin
      frame.push_back(wData[8*i +: 8]);
    end
    runCmd(port, frame, status, rData);
    checkEq(status, expStatus, $sformatf("write status, port %0d addr 0x%02h", port, addr));
  endtask

  task automatic readReg(input int port, input logic [7:0] addr, input logic [7:0] expStatus,
                         input logic [31:0] expData);
    logic [7:0]  frame[$];
    logic [7:0]  status;
    logic [31:0] rData;
    frame.push_back(cosPkg::OpRead);
    frame.push_back(addr);
    runCmd(port, frame, status, rData);
    checkEq(status, expStatus, $sformatf("read status, port %0d addr 0x%02h", port, addr));
    if (expStatus == cosPkg::StatusOk) begin
      checkEq(rData, expData, $sformatf("read data, port %0d addr 0x%02h", port, addr));
    end
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************

  task automatic testReset();
    checkEq(ledOut, 0, "ledOut after reset");
    repeat (50) begin
      @(negedge clockRef);
      checkEq(uartTx, 2'b11, "idle uartTx after reset");
    end
  endtask

  task automatic testScratch();
    logic [31:0] value;
    value = lcgNext();
    writeReg(1, cosPkg::AddrScratch, value, cosPkg::StatusOk);
    expScratch = value;
    readReg(0, cosPkg::AddrScratch, cosPkg::StatusOk, expScratch);
  endtask

  task automatic testLed();
    logic [31:0] value;
    for (int port = 0; port < cosPkg::UartCount; port++) begin
      value = lcgNext();
      writeReg(port, cosPkg::AddrLed, value, cosPkg::StatusOk);
      expLed = value[cosPkg::LedCount-1:0];
      checkEq(ledOut, expLed, "ledOut after LED write");
      readReg(port, cosPkg::AddrLed, cosPkg::StatusOk, {29'b0, expLed});
    end
  endtask

  task automatic testErrors();
    logic [7:0]  frame[$];
    logic [7:0]  status;
    logic [31:0] rData;
    readReg(0, 8'h40, cosPkg::StatusErr, 32'h0);
    writeReg(1, 8'h06, lcgNext(), cosPkg::StatusErr);
    writeReg(0, cosPkg::AddrId, lcgNext(), cosPkg::StatusErr);
    frame.push_back(8'hA5);
    runCmd(1, frame, status, rData);
    checkEq(status, cosPkg::StatusBadOp, "unknown opcode status");
    // Registers untouched by the failed commands
    readReg(0, cosPkg::AddrScratch, cosPkg::StatusOk, expScratch);
    readReg(1, cosPkg::AddrLed, cosPkg::StatusOk, {29'b0, expLed});
    checkEq(ledOut, expLed, "ledOut after error cases");
  endtask

  task automatic testConcurrent();
    logic [31:0] value;
    value = lcgNext();
    fork
      writeReg(0, cosPkg::AddrScratch, value, cosPkg::StatusOk);
      readReg(1, cosPkg::AddrId, cosPkg::StatusOk, cosPkg::CosId);
    join
    expScratch = value;
    readReg(1, cosPkg::AddrScratch, cosPkg::StatusOk, expScratch);
  endtask

  initial begin
    uartRx     = '1;
    arstN      = 1'b0;
    lcgState   = 32'd24;
    expScratch = '0;
    expLed     = '0;
    repeat (2) @(posedge clockRef);
    arstN <= 1'b1;
    testReset();
    readReg(0, cosPkg::AddrId, cosPkg::StatusOk, cosPkg::CosId);
    testScratch();
    testLed();
    testErrors();
    testConcurrent();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
cosPkg.sv
uartLink.sv
cmdEngine.sv
axilArbiter.sv
statusRegs.sv
chipCore.sv
cosTb_chk.sv
cosTb.sv

//--- Bender.yml
package:
  name: cos_core

sources:
  - cosPkg.sv
  - uartLink.sv
  - cmdEngine.sv
  - axilArbiter.sv
  - statusRegs.sv
  - chipCore.sv
  - target: simulation
    files:
      - cosTb_chk.sv
      - cosTb.sv
